// ==== design/btac.sv ====
`timescale 1ns/10ps
`default_nettype none

module btac (
  input logic clock,
  input logic reset,
  input btac_pkg::btac_req_t req,
  output btac_pkg::btac_rsp_t rsp
);

  btac_pkg::btb_read_t rd;
  btac_pkg::btb_write_t wr;
  btac_pkg::btb_data_t data;
  logic pred_branch;
  logic [31:0] pred_baddr;
  logic [31:0] pred_pc;
  logic [31:0] pred_npc;
  logic [31:0] pred_maddr;
  logic pred_miss;
  logic pred_hazard;
  btac_pkg::miss_e pred_kind;

  btb_array btb_array0 (
    .clock (clock),
    .reset (reset),
    .rd (rd),
    .wr (wr),
    .data (data)
  );

  btac_predict btac_predict0 (
    .clock (clock),
    .reset (reset),
    .req (req),
    .rd (rd),
    .data (data),
    .pred_branch (pred_branch),
    .pred_baddr (pred_baddr),
    .pred_pc (pred_pc),
    .pred_npc (pred_npc)
  );

  btac_resolve btac_resolve0 (
    .clock (clock),
    .reset (reset),
    .req (req),
    .wr (wr),
    .pred_maddr (pred_maddr),
    .pred_miss (pred_miss),
    .pred_hazard (pred_hazard),
    .pred_kind (pred_kind)
  );

  assign rsp = '{pred_branch: pred_branch, pred_baddr: pred_baddr, pred_pc: pred_pc,
                 pred_npc: pred_npc, pred_maddr: pred_maddr, pred_miss: pred_miss,
                 pred_hazard: pred_hazard, pred_kind: pred_kind};

endmodule

`default_nettype wire

// ==== design/btac_pkg.sv ====
`default_nettype none

package btac_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Table geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int btb_entries = 64;
  localparam int btb_index_bits = $clog2(btb_entries);
  localparam int stage_count = 5;

  ////////////////////////////////////////////////////////////////////////////
  // BTB storage
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [31:0] target;                   // Predicted branch target
    logic [31:0] pc;                       // Branch PC that doubles as the tag
    logic [31:0] npc;                      // Fall-through PC
  } btb_entry_t;

  typedef struct packed {
    logic en;
    logic [btb_index_bits-1:0] index;
    btb_entry_t entry;
  } btb_write_t;

  typedef struct packed {
    logic [btb_index_bits-1:0] index0;
    logic [btb_index_bits-1:0] index1;
  } btb_read_t;

  typedef struct packed {
    btb_entry_t entry0;
    btb_entry_t entry1;
  } btb_data_t;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline records and update slots
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    stage_fetch,
    stage_decode,
    stage_issue,
    stage_execute,
    stage_memory
  } stage_e;

  typedef struct packed {
    logic taken;
    logic [31:0] target;
    logic [31:0] pc;
    logic [31:0] npc;
  } stage_rec_t;

  typedef struct packed {
    logic jal;
    logic branch;
    logic jump;                            // Set when the jump or branch was taken
    logic [31:0] pc;
    logic [31:0] target;
    logic [31:0] npc;
  } upd_slot_t;

  typedef enum logic [1:0] {
    miss_none,
    miss_wrong_target,
    miss_false_taken,
    miss_unpredicted_jump
  } miss_e;

  ////////////////////////////////////////////////////////////////////////////
  // Block interface
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic clear;
    logic stall;
    logic [1:0][31:0] fetch_pc;
    upd_slot_t [1:0] upd;
    stage_rec_t [stage_count-1:0] rec;     // Indexed by stage_e
  } btac_req_t;

  typedef struct packed {
    logic pred_branch;
    logic [31:0] pred_baddr;
    logic [31:0] pred_pc;
    logic [31:0] pred_npc;
    logic [31:0] pred_maddr;
    logic pred_miss;
    logic pred_hazard;
    miss_e pred_kind;
  } btac_rsp_t;

endpackage

`default_nettype wire

// ==== design/btac_predict.sv ====
`timescale 1ns/10ps
`default_nettype none

module btac_predict (
  input logic clock,
  input logic reset,
  input btac_pkg::btac_req_t req,
  output btac_pkg::btb_read_t rd,
  input btac_pkg::btb_data_t data,
  output logic pred_branch,
  output logic [31:0] pred_baddr,
  output logic [31:0] pred_pc,
  output logic [31:0] pred_npc
);

  logic [1:0][31:0] pc_q;                  // Compare PCs for the entries in flight
  logic [1:0][31:0] pc_next;
  logic [1:0] hit;
  btac_pkg::btb_entry_t sel;

  // Clear freezes the lookup on the previous PCs
  assign pc_next = req.clear ? pc_q : req.fetch_pc;

  assign rd.index0 = pc_next[0][btac_pkg::btb_index_bits+1:2];
  assign rd.index1 = pc_next[1][btac_pkg::btb_index_bits+1:2];

  always_ff @(posedge clock) begin
    if (!reset) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Tag compare and slot select
  ////////////////////////////////////////////////////////////////////////////

  assign hit[0] = (|data.entry0) && (data.entry0.pc == pc_q[0]);
  assign hit[1] = (|data.entry1) && (data.entry1.pc == pc_q[1]);

  assign sel = hit[0] ? data.entry0 : data.entry1; // Earlier slot wins

  always_comb begin
    if (req.stall || req.clear) begin
      pred_branch = 1'b0;
      pred_baddr = '0;
      pred_pc = '0;
      pred_npc = '0;
    end else begin
      pred_branch = |hit;
      pred_baddr = (|hit) ? sel.target : '0;
      pred_pc = (|hit) ? sel.pc : '0;
      pred_npc = (|hit) ? sel.npc : '0;
    end
  end

endmodule

`default_nettype wire

// ==== design/btac_resolve.sv ====
`timescale 1ns/10ps
`default_nettype none

module btac_resolve (
  input logic clock,
  input logic reset,
  input btac_pkg::btac_req_t req,
  output btac_pkg::btb_write_t wr,
  output logic [31:0] pred_maddr,
  output logic pred_miss,
  output logic pred_hazard,
  output btac_pkg::miss_e pred_kind
);

  btac_pkg::upd_slot_t upd0;
  btac_pkg::upd_slot_t upd1;
  btac_pkg::upd_slot_t wsel;
  btac_pkg::stage_e match_stage;
  btac_pkg::stage_rec_t match_rec;
  logic found;
  logic [31:0] maddr;
  logic [1:0] miss;
  btac_pkg::miss_e kind;
  logic [31:0] maddr_q;
  logic [1:0] miss_q;
  btac_pkg::miss_e kind_q;

  assign upd0 = req.upd[0];
  assign upd1 = req.upd[1];

  ////////////////////////////////////////////////////////////////////////////
  // BTB write from taken jumps
  ////////////////////////////////////////////////////////////////////////////

  assign wsel = upd0.jump ? upd0 : upd1;   // Slot 0 goes first when both jump

  assign wr.en = !req.clear && (((upd0.jal || upd0.branch) && upd0.jump) ||
                                ((upd1.jal || upd1.branch) && upd1.jump));
  assign wr.index = wsel.pc[btac_pkg::btb_index_bits+1:2];
  assign wr.entry = '{target: wsel.target, pc: wsel.pc, npc: wsel.npc};

  ////////////////////////////////////////////////////////////////////////////
  // Stage record search and miss rules
  ////////////////////////////////////////////////////////////////////////////

  // Later stages overwrite earlier ones, so memory ends up on top
  always_comb begin
    found = 1'b0;
    match_stage = btac_pkg::stage_fetch;
    for (int s = 0; s < btac_pkg::stage_count; s++) begin
      if (req.rec[s].taken && (req.rec[s].pc == upd0.pc || req.rec[s].pc == upd1.pc)) begin
        found = 1'b1;
        match_stage = btac_pkg::stage_e'(s);
      end
    end
  end

  assign match_rec = req.rec[match_stage];

  always_comb begin
    maddr = '0;
    miss = 2'b00;
    kind = btac_pkg::miss_none;
    if (req.clear) begin
      kind = btac_pkg::miss_none;          // Flushed updates never miss
    end else if (found && upd0.pc == match_rec.pc) begin
      if (upd0.jump) begin
        maddr = upd0.target;
        miss[0] = upd0.target != match_rec.target;
        kind = miss[0] ? btac_pkg::miss_wrong_target : btac_pkg::miss_none;
      end else if (upd0.branch) begin
        maddr = match_rec.npc;
        miss[0] = 1'b1;
        kind = btac_pkg::miss_false_taken;
      end
    end else if (found) begin
      if (upd1.jump) begin
        maddr = upd1.target;
        miss[1] = upd1.target != match_rec.target;
        kind = miss[1] ? btac_pkg::miss_wrong_target : btac_pkg::miss_none;
      end else if (upd1.branch) begin
        maddr = match_rec.npc;
        miss[1] = 1'b1;
        kind = btac_pkg::miss_false_taken;
      end
    end else if (upd0.jump) begin
      maddr = upd0.target;
      miss[0] = 1'b1;
      kind = btac_pkg::miss_unpredicted_jump;
    end else if (upd1.jump) begin
      maddr = upd1.target;
      miss[1] = 1'b1;
      kind = btac_pkg::miss_unpredicted_jump;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      miss_q <= 2'b00;
      kind_q <= btac_pkg::miss_none;
    end else begin
      miss_q <= miss;
      kind_q <= kind;
    end
  end

  always_ff @(posedge clock) begin
    maddr_q <= maddr;
  end

  assign pred_maddr = maddr_q;
  assign pred_miss = |miss_q;
  assign pred_kind = kind_q;
  assign pred_hazard = miss[0];            // Slot 0 redirect is known this cycle

endmodule

`default_nettype wire

// ==== design/btb_array.sv ====
`timescale 1ns/10ps
`default_nettype none

module btb_array (
  input logic clock,
  input logic reset,
  input btac_pkg::btb_read_t rd,
  input btac_pkg::btb_write_t wr,
  output btac_pkg::btb_data_t data
);

  btac_pkg::btb_entry_t mem [btac_pkg::btb_entries];
  btac_pkg::btb_entry_t rdata0;
  btac_pkg::btb_entry_t rdata1;

  // An all-zero entry is the empty marker, so the whole table is wiped
  // while reset is held
  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < btac_pkg::btb_entries; i++) begin
        mem[i] <= '0;
      end
    end else if (wr.en) begin
      mem[wr.index] <= wr.entry;
    end
  end

  // Read data is captured at the same edge as a write and sees the old entry
  always_ff @(posedge clock) begin
    if (!reset) begin
      rdata0 <= '0;
      rdata1 <= '0;
    end else begin
      rdata0 <= mem[rd.index0];
      rdata1 <= mem[rd.index1];
    end
  end

  assign data.entry0 = rdata0;
  assign data.entry1 = rdata1;

endmodule

`default_nettype wire

// ==== filelist.f ====
design/btac_pkg.sv
design/btb_array.sv
design/btac_predict.sv
design/btac_resolve.sv
design/btac.sv
verif/btac_asserts.sv
verif/btac_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the BTAC testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module btac_tb -f filelist.f

# Keep running past assertion errors so the testbench prints its summary
./obj_dir/Vbtac_tb +verilator+error+limit+1000 | tee sim.log

if grep -q "TEST FAIL" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"

// ==== verif/btac_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module btac_asserts (
  input logic clock,
  input logic reset,
  input btac_pkg::btac_req_t req,
  input btac_pkg::btac_rsp_t rsp
);

  int failures = 0;                        // Read by the testbench at the end of the run

  miss_low_in_reset: assert property (@(posedge clock) !reset |=> !rsp.pred_miss)
    else begin
      failures = failures + 1;
      $error("pred_miss is set after a reset cycle");
    end

  // The prediction is gated in the output cycle itself
  branch_low_on_stall: assert property (@(posedge clock) disable iff (!reset)
    (req.stall || req.clear) |-> !rsp.pred_branch)
    else begin
      failures = failures + 1;
      $error("pred_branch is set while stall or clear is high");
    end

  hazard_then_miss: assert property (@(posedge clock) disable iff (!reset)
    rsp.pred_hazard |=> rsp.pred_miss)
    else begin
      failures = failures + 1;
      $error("pred_hazard was not followed by pred_miss");
    end

  kind_matches_miss: assert property (@(posedge clock) disable iff (!reset)
    (rsp.pred_kind == btac_pkg::miss_none) == !rsp.pred_miss)
    else begin
      failures = failures + 1;
      $error("pred_kind disagrees with pred_miss");
    end

endmodule

bind btac btac_asserts btac_asserts0 (
  .clock (clock),
  .reset (reset),
  .req (req),
  .rsp (rsp)
);

`default_nettype wire

// ==== verif/btac_patterns.txt ====
# One cycle per line in hex. md 1 = idle (random untaken records), u0f/u1f = {jal,branch,jump}
# md cl st fpc0 fpc1 u0f u0pc u0tg u1f u1pc u1tg dt dtg dpc dnpc mt mtg mpc mnpc br bad bpc bnp ms mad hz kd
# Empty table after reset
1 0 0 40  80  0 0   0   0 0   0   0 0   0   0   0 0   0   0   0 0   0   0   0 0   0 0
# Jal at 40 is written and also misses as an unpredicted jump
0 0 0 40  80  5 40  200 0 0   0   0 0   0   0   0 0   0   0   0 0   0   0   1 200 1 3
1 0 0 40  80  0 0   0   0 0   0   0 0   0   0   0 0   0   0   1 200 40  44  0 0   0 0
# Slot 1 hit while a slot 1 branch at 80 is written
1 0 0 80  40  0 0   0   3 80  300 0 0   0   0   0 0   0   0   1 200 40  44  1 300 0 3
1 0 0 80  40  0 0   0   0 0   0   0 0   0   0   0 0   0   0   1 300 80  84  0 0   0 0
# Alias of 40, then stall, then clear with a dropped update
1 0 0 140 c0  0 0   0   0 0   0   0 0   0   0   0 0   0   0   0 0   0   0   0 0   0 0
1 0 1 40  c0  0 0   0   0 0   0   0 0   0   0   0 0   0   0   0 0   0   0   0 0   0 0
1 1 0 40  c0  5 c0  400 0 0   0   0 0   0   0   0 0   0   0   0 0   0   0   0 0   0 0
1 0 0 c0  40  0 0   0   0 0   0   0 0   0   0   0 0   0   0   1 200 40  44  0 0   0 0
# Memory record with a stale target, then a matching target
0 0 0 40  c0  5 40  240 0 0   0   0 0   0   0   1 200 40  44  1 200 40  44  1 240 1 1
0 0 0 40  c0  5 40  240 0 0   0   0 0   0   0   1 240 40  44  1 240 40  44  0 0   0 0
# Not-taken branches against taken records
0 0 0 c0  c0  2 80  0   0 0   0   0 0   0   0   1 300 80  84  0 0   0   0   1 84  1 2
0 0 0 c0  c0  0 0   0   2 80  0   1 310 80  90  1 300 80  84  0 0   0   0   1 84  0 2
# Memory record outranks decode on a target compare
0 0 0 c0  c0  3 80  300 0 0   0   1 300 80  84  1 320 80  84  0 0   0   0   1 300 1 1
1 0 0 80  40  0 0   0   0 0   0   0 0   0   0   0 0   0   0   1 300 80  84  0 0   0 0
1 0 0 0   0   0 0   0   0 0   0   0 0   0   0   0 0   0   0   0 0   0   0   0 0   0 0

// ==== verif/btac_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module btac_tb;

  localparam int max_lines = 200;          // Upper bound on the pattern file length
  localparam int field_count = 27;

  logic clock = 1'b0;
  logic reset;
  btac_pkg::btac_req_t req;
  btac_pkg::btac_rsp_t rsp;

  logic [31:0] f [field_count];            // Fields of the current pattern line
  integer seed;
  int fd;
  int n;
  int lines;
  int line_no;
  int checked;
  int errors;
  int assert_errors;
  string text;

  btac dut0 (
    .clock (clock),
    .reset (reset),
    .req (req),
    .rsp (rsp)
  );

  always #4 clock = ~clock;

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and response checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_request();
    logic idle;
    idle = f[0][0];
    req.clear = f[1][0];
    req.stall = f[2][0];
    req.fetch_pc[0] = f[3];
    req.fetch_pc[1] = f[4];
    req.upd[0] = '{jal: f[5][2], branch: f[5][1], jump: f[5][0],
                   pc: f[6], target: f[7], npc: f[6] + 32'd4};
    req.upd[1] = '{jal: f[8][2], branch: f[8][1], jump: f[8][0],
                   pc: f[9], target: f[10], npc: f[9] + 32'd4};
    for (int s = 0; s < btac_pkg::stage_count; s++) begin
      if (idle) begin
        req.rec[s].taken = 1'b0;           // Untaken records never match
        req.rec[s].target = $random(seed);
        req.rec[s].pc = $random(seed);
        req.rec[s].npc = $random(seed);
      end else begin
        req.rec[s] = '0;
      end
    end
    if (!idle) begin
      req.rec[btac_pkg::stage_decode] = '{taken: f[11][0], target: f[12], pc: f[13], npc: f[14]};
      req.rec[btac_pkg::stage_memory] = '{taken: f[15][0], target: f[16], pc: f[17], npc: f[18]};
    end
  endtask

  task automatic compare_field(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %0t line %0d %s is %h, expected %h", $time, line_no, name, got, exp);
    end
  endtask

  task automatic check_response();
    compare_field("pred_branch", {31'd0, rsp.pred_branch}, f[19]);
    compare_field("pred_baddr", rsp.pred_baddr, f[20]);
    compare_field("pred_pc", rsp.pred_pc, f[21]);
    compare_field("pred_npc", rsp.pred_npc, f[22]);
    compare_field("pred_miss", {31'd0, rsp.pred_miss}, f[23]);
    if (f[23][0]) begin
      compare_field("pred_maddr", rsp.pred_maddr, f[24]); // Redirect address is defined on a miss
    end
    compare_field("pred_hazard", {31'd0, rsp.pred_hazard}, f[25]);
    compare_field("pred_kind", {30'd0, rsp.pred_kind}, f[26]);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    reset = 1'b0;
    req = '0;
    seed = 32'h3edd_ea97;
    errors = 0;
    checked = 0;
    lines = 0;
    line_no = 0;
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;

    fd = $fopen("verif/btac_patterns.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the pattern file verif/btac_patterns.txt");
    end else begin
      while (!$feof(fd) && lines < max_lines) begin
        lines++;
        text = "";
        n = $fgets(text, fd);
        if (n > 0) begin
          n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                      f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20],
                      f[21], f[22], f[23], f[24], f[25], f[26]);
        end
        if (n == field_count) begin
          line_no = lines;
          @(negedge clock);
          drive_request();
          @(posedge clock);
          #3;                              // Just ahead of the next falling edge
          check_response();
          checked++;
        end else if (n > 0) begin
          errors++;
          $display("Pattern line %0d is malformed with %0d of %0d fields", lines, n, field_count);
        end
      end
      if (!$feof(fd)) begin
        errors++;
        $display("Pattern file is longer than %0d lines and reading stopped", max_lines);
      end
      $fclose(fd);
    end
    if (checked == 0) begin
      errors++;
      $display("No pattern line was applied");
    end

    assert_errors = dut0.btac_asserts0.failures;
    $display("Errors: %0d checks, %0d assertions over %0d cycles", errors, assert_errors, checked);
    if (errors == 0 && assert_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
